/* source/veripacParams.svh */
`ifndef VERIPAC_PARAMS_SVH
`define VERIPAC_PARAMS_SVH

// Program RAM size, also the address of the control/status register
`define VERIPAC_RAM_LENGTH 8'd202

// Special registers right after the RAM
`define VERIPAC_KEYBOARD_REG 8'd203
`define VERIPAC_ACCUMULATOR 8'd204
`define VERIPAC_PROGRAM_COUNTER 8'd205
`define VERIPAC_INSTRUCTION_REG 8'd206
`define VERIPAC_DATA_COUNTER 8'd207

// General registers occupy the top of the map
`define VERIPAC_REGS_START 8'd240
`define VERIPAC_NUM_REGS 16

// BDB branches when the accumulator is inside this range
`define VERIPAC_BDB_LOW 8'd90
`define VERIPAC_BDB_HIGH 8'd99

`endif

/* source/veripacPkg.sv */
package veripacPkg;

    typedef logic [7:0] byte_t;
    typedef logic [3:0] regIdx_t;

    typedef enum logic [1:0] {
        FETCH1 = 2'd0,
        FETCH2 = 2'd1,
        EXEC   = 2'd2,
        HALT   = 2'd3
    } ucState_e;

    // Opcodes decoded on the whole byte
    typedef enum logic [7:0] {
        I_NOP    = 8'h00,
        I_CLR    = 8'h01,
        I_DEC    = 8'h02,
        I_INC    = 8'h03,
        I_LDVANN = 8'h0A,
        I_BDBNN  = 8'h10,
        I_BDCNN  = 8'h11,
        I_GTONN  = 8'h12,
        I_BRZNN  = 8'h13,
        I_HALT   = 8'hFF
    } opcode_e;

    // Register opcodes, upper nibble only; lower nibble selects Ri
    typedef enum logic [3:0] {
        G_BNERNN = 4'h2,
        G_BEQRNN = 4'h3,
        G_BGTRNN = 4'h4,
        G_BLTRNN = 4'h5,
        G_LDVRNN = 4'h6,
        G_PAKR   = 4'h8,
        G_LDAR   = 4'h9,
        G_STOR   = 4'hA,
        G_UNPR   = 4'hB,
        G_SUBR   = 4'hD,
        G_ADDR   = 4'hE
    } opGroup_e;

    typedef struct packed {
        byte_t addr;
        logic  rd;
        logic  wr;
        byte_t din;
    } hostReq_t;

    typedef struct packed {
        logic ram;
        logic regs;
        logic status;
        logic acc;
        logic pc;
        logic ir;
        logic dc;
    } hostSel_t;

    typedef struct packed {
        logic    en;
        regIdx_t idx;
        byte_t   data;
    } regWrite_t;

    typedef struct packed {
        byte_t ir;
        byte_t dc;
        byte_t ri;
    } instr_t;

    function automatic logic isTwoByte(byte_t firstByte);
        return (firstByte[7:4] >= 4'h1 && firstByte[7:4] <= 4'h6) ||
               (firstByte == I_LDVANN);
    endfunction

    function automatic logic isRegisterOp(byte_t firstByte);
        return firstByte[7:4] >= 4'h2 && firstByte[7:4] <= 4'hE;
    endfunction

endpackage

/* source/busDecoder.sv */
`include "veripacParams.svh"

module busDecoder
    import veripacPkg::*;
(
    input  hostReq_t req,
    output hostSel_t sel,
    input  byte_t    ramData,
    input  byte_t    regData,
    input  byte_t    acc,
    input  byte_t    pc,
    input  byte_t    ir,
    input  byte_t    dc,
    input  ucState_e state,
    output byte_t    dout
);

    always_comb begin
        sel = '0;
        if (req.addr < `VERIPAC_RAM_LENGTH) begin
            sel.ram = 1'b1;
        end else if (req.addr >= `VERIPAC_REGS_START) begin
            sel.regs = 1'b1;
        end else begin
            case (req.addr)
                `VERIPAC_RAM_LENGTH:      sel.status = 1'b1;
                `VERIPAC_ACCUMULATOR:     sel.acc = 1'b1;
                `VERIPAC_PROGRAM_COUNTER: sel.pc = 1'b1;
                `VERIPAC_INSTRUCTION_REG: sel.ir = 1'b1;
                `VERIPAC_DATA_COUNTER:    sel.dc = 1'b1;
                // Keyboard is gone, its address stays unmapped
                default:                  sel = '0;
            endcase
        end
    end

    // Read mux, zero when idle or unmapped
    always_comb begin
        dout = '0;
        if (req.rd) begin
            if (sel.ram) begin
                dout = ramData;
            end else if (sel.regs) begin
                dout = regData;
            end else if (sel.status) begin
                dout = {6'b0, state};
            end else if (sel.acc) begin
                dout = acc;
            end else if (sel.pc) begin
                dout = pc;
            end else if (sel.ir) begin
                dout = ir;
            end else if (sel.dc) begin
                dout = dc;
            end
        end
    end

endmodule

/* source/programMemory.sv */
`include "veripacParams.svh"

module programMemory
    import veripacPkg::*;
(
    input  logic     clk,
    input  hostReq_t req,
    input  hostSel_t hostSel,
    input  byte_t    fetchAddr,
    output byte_t    hostData,
    output byte_t    fetchData
);

    byte_t mem [`VERIPAC_RAM_LENGTH];

    initial begin
        for (int i = 0; i < `VERIPAC_RAM_LENGTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (hostSel.ram && req.wr) begin
            mem[req.addr] <= req.din;
        end
    end

    assign hostData = hostSel.ram ? mem[req.addr] : '0;

    // Past the end the control unit halts, so the byte is never used
    assign fetchData = (fetchAddr < `VERIPAC_RAM_LENGTH) ? mem[fetchAddr] : '0;

endmodule

/* source/registerFile.sv */
`include "veripacParams.svh"

module registerFile
    import veripacPkg::*;
(
    input  logic      clk,
    input  hostReq_t  req,
    input  hostSel_t  hostSel,
    input  regIdx_t   readIdx,
    output byte_t     readData,
    output byte_t     hostData,
    input  regWrite_t writeA,
    input  regWrite_t writeB
);

    byte_t   regs [`VERIPAC_NUM_REGS];
    regIdx_t hostIdx;

    initial begin
        for (int i = 0; i < `VERIPAC_NUM_REGS; i++) begin
            regs[i] = '0;
        end
    end

    assign hostIdx = regIdx_t'(req.addr - `VERIPAC_REGS_START);

    // Host and core writes are never in the same cycle
    always_ff @(posedge clk) begin
        if (hostSel.regs && req.wr) begin
            regs[hostIdx] <= req.din;
        end else begin
            if (writeA.en) begin
                regs[writeA.idx] <= writeA.data;
            end
            // Port B only used by UNPR, one index above port A
            if (writeB.en) begin
                regs[writeB.idx] <= writeB.data;
            end
        end
    end

    assign readData = regs[readIdx];
    assign hostData = hostSel.regs ? regs[hostIdx] : '0;

endmodule

/* source/controlUnit.sv */
`include "veripacParams.svh"

module controlUnit
    import veripacPkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  hostReq_t req,
    input  hostSel_t hostSel,
    input  logic     step,
    input  byte_t    fetchData,
    input  byte_t    ri,
    input  logic     branchTaken,
    input  logic     halt,
    output byte_t    fetchAddr,
    output regIdx_t  riIdx,
    output instr_t   instr,
    output logic     execStrobe,
    output ucState_e state,
    output byte_t    pc,
    output byte_t    ir,
    output byte_t    dc
);

    logic  stepPrev;
    logic  stepEdge;
    logic  advance;
    byte_t riReg;

    // Edges during host access are lost
    assign stepEdge = step && !stepPrev && !req.rd && !req.wr;

    // Step history, and the one-cycle delay before the state moves
    always_ff @(posedge clk) begin
        if (reset) begin
            stepPrev   <= 1'b0;
            advance    <= 1'b0;
            execStrobe <= 1'b0;
        end else begin
            stepPrev   <= step;
            advance    <= stepEdge;
            execStrobe <= stepEdge && (state == EXEC);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH1;
            pc    <= '0;
        end else begin
            if (advance) begin
                case (state)
                    FETCH1: begin
                        if (pc >= `VERIPAC_RAM_LENGTH) begin
                            state <= HALT;
                        end else begin
                            ir    <= fetchData;
                            pc    <= pc + 8'd1;
                            state <= FETCH2;
                        end
                    end
                    FETCH2: begin
                        if (isTwoByte(ir)) begin
                            dc <= fetchData;
                            pc <= pc + 8'd1;
                        end else begin
                            dc <= '0;
                        end
                        riReg <= isRegisterOp(ir) ? ri : '0;
                        state <= EXEC;
                    end
                    EXEC: begin
                        if (branchTaken) begin
                            pc <= dc;
                        end
                        state <= halt ? HALT : FETCH1;
                    end
                    // HALT waits for reset
                    default: state <= HALT;
                endcase
            end
            // Host writes win on their own register
            if (req.wr && hostSel.pc) begin
                pc <= req.din;
            end
            if (req.wr && hostSel.ir) begin
                ir <= req.din;
            end
            if (req.wr && hostSel.dc) begin
                dc <= req.din;
            end
        end
    end

    assign fetchAddr = pc;
    assign riIdx     = ir[3:0];
    assign instr     = '{ir: ir, dc: dc, ri: riReg};

endmodule

/* source/executeUnit.sv */
`include "veripacParams.svh"

module executeUnit
    import veripacPkg::*;
(
    input  logic      clk,
    input  hostReq_t  req,
    input  hostSel_t  hostSel,
    input  instr_t    instr,
    input  logic      execStrobe,
    output byte_t     acc,
    output logic      branchTaken,
    output logic      halt,
    output regWrite_t writeA,
    output regWrite_t writeB
);

    byte_t    accReg;
    byte_t    accNext;
    regIdx_t  dstIdx;
    opcode_e  op;
    opGroup_e grp;

    assign dstIdx = instr.ir[3:0];
    assign op     = opcode_e'(instr.ir);
    assign grp    = opGroup_e'(instr.ir[7:4]);

    // Dropped and undefined opcodes fall through as NOP
    always_comb begin
        accNext     = accReg;
        branchTaken = 1'b0;
        halt        = 1'b0;
        writeA      = '{en: 1'b0, idx: dstIdx, data: accReg};
        writeB      = '{en: 1'b0, idx: dstIdx + 4'd1, data: {4'h0, accReg[3:0]}};
        if (isRegisterOp(instr.ir)) begin
            case (grp)
                G_BNERNN: branchTaken = (accReg != instr.ri);
                G_BEQRNN: branchTaken = (accReg == instr.ri);
                G_BGTRNN: branchTaken = (instr.ri > accReg);
                G_BLTRNN: branchTaken = (instr.ri < accReg);
                G_LDVRNN: begin
                    writeA.en   = execStrobe;
                    writeA.data = instr.dc;
                end
                // Ri was latched from the same register in FETCH2
                G_PAKR:   accNext = {instr.ri[3:0], instr.ri[3:0]};
                G_LDAR:   accNext = instr.ri;
                G_STOR:   writeA.en = execStrobe;
                G_UNPR: begin
                    writeA.en   = execStrobe;
                    writeA.data = {4'h0, accReg[7:4]};
                    writeB.en   = execStrobe;
                end
                G_SUBR:   accNext = instr.ri - accReg;
                G_ADDR:   accNext = instr.ri + accReg;
                default:  accNext = accReg;
            endcase
        end else begin
            case (op)
                I_CLR:    accNext = '0;
                I_DEC:    accNext = accReg - 8'd1;
                I_INC:    accNext = accReg + 8'd1;
                I_LDVANN: accNext = instr.dc;
                I_BDBNN: begin
                    branchTaken = (accReg >= `VERIPAC_BDB_LOW) &&
                                  (accReg <= `VERIPAC_BDB_HIGH);
                end
                I_BDCNN:  branchTaken = (accReg != 8'd0);
                I_GTONN:  branchTaken = 1'b1;
                I_BRZNN:  branchTaken = (accReg == 8'd0);
                I_HALT:   halt = 1'b1;
                default:  accNext = accReg;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (hostSel.acc && req.wr) begin
            accReg <= req.din;
        end else if (execStrobe) begin
            accReg <= accNext;
        end
    end

    assign acc = accReg;

endmodule

/* source/veripacTop.sv */
module veripacTop
    import veripacPkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  byte_t addr,
    input  logic  rd,
    input  logic  wr,
    input  byte_t din,
    input  logic  step,
    output byte_t dout
);

    hostReq_t  req;
    hostSel_t  sel;
    byte_t     ramData;
    byte_t     regData;
    byte_t     fetchAddr;
    byte_t     fetchData;
    regIdx_t   riIdx;
    byte_t     riData;
    instr_t    instr;
    logic      execStrobe;
    logic      branchTaken;
    logic      halt;
    regWrite_t writeA;
    regWrite_t writeB;
    byte_t     acc;
    byte_t     pc;
    byte_t     ir;
    byte_t     dc;
    ucState_e  state;

    assign req = '{addr: addr, rd: rd, wr: wr, din: din};

    busDecoder u_busDecoder (
        .req     (req),
        .sel     (sel),
        .ramData (ramData),
        .regData (regData),
        .acc     (acc),
        .pc      (pc),
        .ir      (ir),
        .dc      (dc),
        .state   (state),
        .dout    (dout)
    );

    programMemory u_programMemory (
        .clk       (clk),
        .req       (req),
        .hostSel   (sel),
        .fetchAddr (fetchAddr),
        .hostData  (ramData),
        .fetchData (fetchData)
    );

    registerFile u_registerFile (
        .clk      (clk),
        .req      (req),
        .hostSel  (sel),
        .readIdx  (riIdx),
        .readData (riData),
        .hostData (regData),
        .writeA   (writeA),
        .writeB   (writeB)
    );

    controlUnit u_controlUnit (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .hostSel     (sel),
        .step        (step),
        .fetchData   (fetchData),
        .ri          (riData),
        .branchTaken (branchTaken),
        .halt        (halt),
        .fetchAddr   (fetchAddr),
        .riIdx       (riIdx),
        .instr       (instr),
        .execStrobe  (execStrobe),
        .state       (state),
        .pc          (pc),
        .ir          (ir),
        .dc          (dc)
    );

    executeUnit u_executeUnit (
        .clk         (clk),
        .req         (req),
        .hostSel     (sel),
        .instr       (instr),
        .execStrobe  (execStrobe),
        .acc         (acc),
        .branchTaken (branchTaken),
        .halt        (halt),
        .writeA      (writeA),
        .writeB      (writeB)
    );

endmodule

/* dv/veripacChk.sv */
module veripacChk
    import veripacPkg::*;
(
    input logic     clk,
    input logic     reset,
    input hostReq_t req,
    input logic     step,
    input logic     execStrobe,
    input ucState_e state
);
    timeunit 1ns;
    timeprecision 1ps;

    logic stepSeen;
    logic edgeOk;

    always_ff @(posedge clk) begin
        if (reset) begin
            stepSeen <= 1'b0;
        end else begin
            stepSeen <= step;
        end
    end

    // Rising step edge outside host access
    assign edgeOk = step && !stepSeen && !req.rd && !req.wr;

    resetToFetch1: assert property (@(posedge clk) reset |=> state == FETCH1)
        else $error("state is not FETCH1 after reset");

    haltHolds: assert property (@(posedge clk) state == HALT && !reset |=> state == HALT)
        else $error("state left HALT without a reset");

    changeNeedsEdge: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) && state != $past(state) |-> $past(edgeOk, 2))
        else $error("state changed without an accepted step edge");

    strobeInExec: assert property (@(posedge clk) disable iff (reset)
        execStrobe |-> state == EXEC)
        else $error("execStrobe high outside EXEC");

endmodule

bind controlUnit veripacChk u_veripacChk (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .step       (step),
    .execStrobe (execStrobe),
    .state      (state)
);

/* dv/veripacTb.sv */
`include "veripacParams.svh"

module veripacTb
    import veripacPkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic  clk;
    logic  reset;
    byte_t addr;
    logic  rd;
    logic  wr;
    byte_t din;
    logic  step;
    byte_t dout;

    // Reference model of the machine state
    byte_t    mRam [`VERIPAC_RAM_LENGTH];
    byte_t    mRegs [`VERIPAC_NUM_REGS];
    byte_t    mAcc;
    byte_t    mPc;
    byte_t    mIr;
    byte_t    mDc;
    byte_t    mRi;
    ucState_e mState;

    byte_t       prog [$];
    int          valueErrors = 0;
    int          timeoutErrors = 0;
    logic [31:0] rngState = 32'd84;

    veripacTop u_veripacTop (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic byte_t randomByte();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState[7:0];
    endfunction

    // Advances the model by one control state
    function automatic void refRun();
        logic    taken;
        regIdx_t i;
        regIdx_t nextIdx;
        taken = 1'b0;
        i = mIr[3:0];
        nextIdx = i + 4'd1;
        case (mState)
            FETCH1: begin
                if (mPc >= `VERIPAC_RAM_LENGTH) begin
                    mState = HALT;
                end else begin
                    mIr = mRam[mPc];
                    mPc = mPc + 8'd1;
                    mState = FETCH2;
                end
            end
            FETCH2: begin
                mDc = 8'd0;
                if (mIr inside {I_LDVANN, I_BDBNN, I_BDCNN, I_GTONN, I_BRZNN} ||
                    mIr[7:4] inside {[4'h2:4'h6]}) begin
                    mDc = mRam[mPc];
                    mPc = mPc + 8'd1;
                end
                mRi = (mIr[7:4] inside {[4'h2:4'hE]}) ? mRegs[mIr[3:0]] : 8'd0;
                mState = EXEC;
            end
            EXEC: begin
                mState = FETCH1;
                case (mIr[7:4])
                    G_BNERNN: taken = (mAcc != mRi);
                    G_BEQRNN: taken = (mAcc == mRi);
                    G_BGTRNN: taken = (mRi > mAcc);
                    G_BLTRNN: taken = (mRi < mAcc);
                    G_LDVRNN: mRegs[i] = mDc;
                    G_PAKR:   mAcc = {mRi[3:0], mRi[3:0]};
                    G_LDAR:   mAcc = mRi;
                    G_STOR:   mRegs[i] = mAcc;
                    G_UNPR: begin
                        mRegs[i] = {4'h0, mAcc[7:4]};
                        mRegs[nextIdx] = {4'h0, mAcc[3:0]};
                    end
                    G_SUBR:   mAcc = mRi - mAcc;
                    G_ADDR:   mAcc = mRi + mAcc;
                    default: begin
                        case (mIr)
                            I_CLR:   mAcc = 8'd0;
                            I_DEC:   mAcc = mAcc - 8'd1;
                            I_INC:   mAcc = mAcc + 8'd1;
                            I_LDVANN: mAcc = mDc;
                            I_BDBNN: taken = (mAcc >= 8'd90) && (mAcc <= 8'd99);
                            I_BDCNN: taken = (mAcc != 8'd0);
                            I_GTONN: taken = 1'b1;
                            I_BRZNN: taken = (mAcc == 8'd0);
                            I_HALT:  mState = HALT;
                            default: ;
                        endcase
                    end
                endcase
                if (taken) begin
                    mPc = mDc;
                end
            end
            default: ;
        endcase
    endfunction

    task automatic hostWrite(input byte_t a, input byte_t d);
        @(negedge clk);
        addr = a;
        din = d;
        wr = 1'b1;
        @(negedge clk);
        wr = 1'b0;
        if (a < `VERIPAC_RAM_LENGTH) begin
            mRam[a] = d;
        end else if (a >= `VERIPAC_REGS_START) begin
            mRegs[regIdx_t'(a - `VERIPAC_REGS_START)] = d;
        end
        case (a)
            `VERIPAC_ACCUMULATOR:     mAcc = d;
            `VERIPAC_PROGRAM_COUNTER: mPc = d;
            `VERIPAC_INSTRUCTION_REG: mIr = d;
            `VERIPAC_DATA_COUNTER:    mDc = d;
            default: ;
        endcase
    endtask

    task automatic hostRead(input byte_t a, output byte_t d);
        @(negedge clk);
        addr = a;
        rd = 1'b1;
        @(posedge clk);
        d = dout;
        @(negedge clk);
        rd = 1'b0;
    endtask

    task automatic stepOnce();
        @(negedge clk);
        rd = 1'b0;
        wr = 1'b0;
        step = 1'b1;
        repeat (2) @(negedge clk);
        step = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    task automatic pulseReset();
        @(negedge clk);
        reset = 1'b1;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        mState = FETCH1;
        mPc = 8'd0;
    endtask

    task automatic checkByte(input string what, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s read 0x%02h, expected 0x%02h", $time, what, got, exp);
            valueErrors++;
        end
    endtask

    task automatic checkState(input string what, input ucState_e got, input ucState_e exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
            valueErrors++;
        end
    endtask

    task automatic compareAll(input string where);
        byte_t got;
        hostRead(`VERIPAC_RAM_LENGTH, got);
        checkState({where, " state"}, ucState_e'(got[1:0]), mState);
        hostRead(`VERIPAC_ACCUMULATOR, got);
        checkByte({where, " acc"}, got, mAcc);
        hostRead(`VERIPAC_PROGRAM_COUNTER, got);
        checkByte({where, " pc"}, got, mPc);
        for (int r = 0; r < `VERIPAC_NUM_REGS; r++) begin
            hostRead(byte_t'(`VERIPAC_REGS_START + r), got);
            checkByte($sformatf("%s r%0d", where, r), got, mRegs[r]);
        end
    endtask

    // Up to three steps, until the model is back in FETCH1 or in HALT
    task automatic runInstr();
        int n;
        n = 0;
        do begin
            stepOnce();
            refRun();
            n++;
        end while (mState != FETCH1 && mState != HALT && n < 3);
    endtask

    task automatic runProgram(input string name);
        int    n;
        byte_t status;
        foreach (prog[k]) hostWrite(byte_t'(k), prog[k]);
        pulseReset();
        n = 0;
        status = 8'd0;
        while (status[1:0] != HALT && n < 40) begin
            runInstr();
            compareAll(name);
            hostRead(`VERIPAC_RAM_LENGTH, status);
            n++;
        end
        if (status[1:0] != HALT) begin
            $display("Timeout: program %s never reached the HALT state", name);
            timeoutErrors++;
        end
    endtask

    task automatic branchCase(input byte_t op, input byte_t a, input byte_t b);
        hostWrite(8'd20, I_HALT);
        prog = '{I_LDVANN, a, 8'h64, b, op, 8'd20, I_HALT};
        runProgram($sformatf("branch 0x%02h", op));
    endtask

    initial begin
        byte_t a;
        byte_t b;
        byte_t c;
        byte_t got;
        byte_t ops [$];
        reset = 1'b1;
        addr = '0;
        rd = 1'b0;
        wr = 1'b0;
        din = '0;
        step = 1'b0;
        foreach (mRam[k]) mRam[k] = '0;
        foreach (mRegs[k]) mRegs[k] = '0;
        mAcc = '0;
        mIr = '0;
        mDc = '0;
        mRi = '0;
        mPc = '0;
        mState = FETCH1;
        repeat (5) @(negedge clk);
        reset = 1'b0;

        hostRead(`VERIPAC_RAM_LENGTH, got);
        checkState("reset state", ucState_e'(got[1:0]), FETCH1);
        hostRead(`VERIPAC_PROGRAM_COUNTER, got);
        checkByte("reset pc", got, 8'd0);
        for (int k = 0; k < 8; k++) begin
            a = randomByte() % `VERIPAC_RAM_LENGTH;
            b = randomByte();
            hostWrite(a, b);
            hostRead(a, got);
            checkByte("ram readback", got, b);
            a = `VERIPAC_REGS_START + (randomByte() % 8'd16);
            b = randomByte();
            hostWrite(a, b);
            hostRead(a, got);
            checkByte("register readback", got, b);
        end
        for (int s = `VERIPAC_ACCUMULATOR; s <= `VERIPAC_DATA_COUNTER; s++) begin
            b = randomByte();
            hostWrite(byte_t'(s), b);
            hostRead(byte_t'(s), got);
            checkByte($sformatf("special %0d readback", s), got, b);
        end
        hostRead(`VERIPAC_KEYBOARD_REG, got);
        checkByte("keyboard address", got, 8'd0);
        hostRead(8'd220, got);
        checkByte("unmapped address", got, 8'd0);

        a = randomByte();
        b = randomByte();
        c = randomByte();
        prog = '{I_LDVANN, a, 8'h63, b, 8'h65, c, 8'h93, 8'hE5, 8'hD3,
                 I_INC, I_DEC, I_DEC, 8'hA7, I_CLR, 8'hA8, I_HALT};
        runProgram("arithmetic");

        ops = '{I_BDBNN, I_BDCNN, I_GTONN, I_BRZNN, 8'h24, 8'h34, 8'h44, 8'h54};
        foreach (ops[k]) begin
            a = randomByte();
            b = randomByte();
            branchCase(ops[k], a, b);
            // Second run flips the outcome
            case (ops[k])
                I_BDBNN: a = `VERIPAC_BDB_LOW + (randomByte() % 8'd10);
                I_BDCNN, I_BRZNN: a = 8'd0;
                8'h24, 8'h34: b = a;
                default: begin
                    c = a;
                    a = b;
                    b = c;
                end
            endcase
            branchCase(ops[k], a, b);
        end

        a = randomByte();
        b = randomByte();
        c = randomByte();
        prog = '{8'h6F, a, 8'h8F, I_LDVANN, b, 8'hBF, I_LDVANN, c, 8'hB6, I_HALT};
        runProgram("nibbles");

        stepOnce();
        refRun();
        stepOnce();
        refRun();
        compareAll("steps in HALT");
        // 0xC3 decodes to no instruction, then the fetch at 202 halts
        hostWrite(8'd201, 8'hC3);
        prog = '{I_GTONN, 8'd201};
        runProgram("end of ram");
        stepOnce();
        refRun();
        compareAll("end of ram hold");

        $display("Value errors: %0d, timeout errors: %0d", valueErrors, timeoutErrors);
        if (valueErrors + timeoutErrors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+source
source/veripacPkg.sv
source/busDecoder.sv
source/programMemory.sv
source/registerFile.sv
source/controlUnit.sv
source/executeUnit.sv
source/veripacTop.sv
dv/veripacChk.sv
dv/veripacTb.sv

/* Bender.yml */
package:
  name: veripac

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/veripacPkg.sv
      - source/busDecoder.sv
      - source/programMemory.sv
      - source/registerFile.sv
      - source/controlUnit.sv
      - source/executeUnit.sv
      - source/veripacTop.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/veripacChk.sv
      - dv/veripacTb.sv
